//--- hw/dispatch_pkg.sv
// Shared widths, RV32I opcode values and dispatch payload types; assumes 32 registers and 16 tags
package dispatch_pkg;

    // Datapath widths
    localparam int DATA_WIDTH    = 32;
    localparam int ADDR_WIDTH    = 32;
    localparam int REG_IDX_WIDTH = 5;
    localparam int NUM_REGS      = 1 << REG_IDX_WIDTH;
    localparam int OPCODE_WIDTH  = 7;

    // Reorder buffer sizing
    localparam int ROB_DEPTH     = 16;
    localparam int ROB_TAG_WIDTH = $clog2(ROB_DEPTH);
    // Extra wrap bit tells full from empty
    localparam int ROB_PTR_WIDTH = ROB_TAG_WIDTH + 1;

    // Base opcodes recognized by decode
    localparam logic [OPCODE_WIDTH-1:0] OPC_LOAD   = 7'b0000011;
    localparam logic [OPCODE_WIDTH-1:0] OPC_OPIMM  = 7'b0010011;
    localparam logic [OPCODE_WIDTH-1:0] OPC_AUIPC  = 7'b0010111;
    localparam logic [OPCODE_WIDTH-1:0] OPC_STORE  = 7'b0100011;
    localparam logic [OPCODE_WIDTH-1:0] OPC_OP     = 7'b0110011;
    localparam logic [OPCODE_WIDTH-1:0] OPC_LUI    = 7'b0110111;
    localparam logic [OPCODE_WIDTH-1:0] OPC_BRANCH = 7'b1100011;
    localparam logic [OPCODE_WIDTH-1:0] OPC_JALR   = 7'b1100111;
    localparam logic [OPCODE_WIDTH-1:0] OPC_JAL    = 7'b1101111;

    typedef enum logic [1:0] {
        ROB_OP_INT = 2'b00,
        ROB_OP_LD  = 2'b01,
        ROB_OP_ST  = 2'b10,
        ROB_OP_BR  = 2'b11
    } rob_op_e;

    // R-type view, also gives rs2 for S and B formats
    typedef struct packed {
        logic [6:0]               funct7;
        logic [REG_IDX_WIDTH-1:0] rs2;
        logic [REG_IDX_WIDTH-1:0] rs1;
        logic [2:0]               funct3;
        logic [REG_IDX_WIDTH-1:0] rd;
        logic [OPCODE_WIDTH-1:0]  opcode;
    } insn_r_t;

    // I-type view
    typedef struct packed {
        logic [11:0]              imm12;
        logic [REG_IDX_WIDTH-1:0] rs1;
        logic [2:0]               funct3;
        logic [REG_IDX_WIDTH-1:0] rd;
        logic [OPCODE_WIDTH-1:0]  opcode;
    } insn_i_t;

    typedef union packed {
        insn_r_t r;
        insn_i_t i;
    } insn_u;

    // Renamed source, rdy set means the value no longer waits on tag
    typedef struct packed {
        logic [ROB_TAG_WIDTH-1:0] tag;
        logic                     rdy;
    } src_t;

    typedef struct packed {
        rob_op_e                  op;
        logic [ADDR_WIDTH-1:0]    pc;
        logic [REG_IDX_WIDTH-1:0] rdest;
        logic [ROB_TAG_WIDTH-1:0] tag;
    } rob_enq_t;

    typedef struct packed {
        logic [OPCODE_WIDTH-1:0]  opcode;
        logic [ADDR_WIDTH-1:0]    pc;
        logic [DATA_WIDTH-1:0]    insn;
        logic [ROB_TAG_WIDTH-1:0] dst_tag;
        src_t                     src1;
        src_t                     src2;
    } rs_enq_t;

    typedef struct packed {
        logic                     valid;
        logic [ROB_TAG_WIDTH-1:0] tag;
    } cdb_t;

    // Marks a source ready when the CDB broadcasts its tag
    function automatic src_t cdb_merge(src_t src, cdb_t cdb);
        src_t merged;
        merged = src;
        if (cdb.valid && (cdb.tag == src.tag)) begin
            merged.rdy = 1'b1;
        end
        return merged;
    endfunction

endpackage

//--- hw/rob_tag_alloc.sv
// Circular ROB tag allocator; retire on an empty allocator is ignored, flush empties it and restarts at tag 0
module rob_tag_alloc (
    input  logic                                   clk,
    input  logic                                   i_rst_n,
    input  logic                                   i_flush,
    input  logic                                   i_alloc_en,
    input  logic                                   i_retire_en,
    output logic [dispatch_pkg::ROB_TAG_WIDTH-1:0] o_tail_tag,
    output logic                                   o_full
);

    logic [dispatch_pkg::ROB_PTR_WIDTH-1:0] head_q;
    logic [dispatch_pkg::ROB_PTR_WIDTH-1:0] tail_q;
    logic [dispatch_pkg::ROB_PTR_WIDTH-1:0] count;
    logic                                   do_alloc;
    logic                                   do_retire;

    // Occupancy from the pointer distance, wrap bit included
    // Both pointers moving together leaves the count as it was
    assign count = tail_q - head_q;

    assign o_full     = (count == dispatch_pkg::ROB_PTR_WIDTH'(dispatch_pkg::ROB_DEPTH));
    assign o_tail_tag = tail_q[dispatch_pkg::ROB_TAG_WIDTH-1:0];

    // Guard against overflow and underflow
    assign do_alloc  = i_alloc_en & ~o_full;
    assign do_retire = i_retire_en & (count != '0);

    // Tail advances per allocation
    always_ff @(posedge clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            tail_q <= '0;
        end else if (i_flush) begin
            tail_q <= '0;
        end else if (do_alloc) begin
            tail_q <= tail_q + dispatch_pkg::ROB_PTR_WIDTH'(1);
        end
    end

    // Head advances per in-order retirement
    always_ff @(posedge clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            head_q <= '0;
        end else if (i_flush) begin
            head_q <= '0;
        end else if (do_retire) begin
            head_q <= head_q + dispatch_pkg::ROB_PTR_WIDTH'(1);
        end
    end

endmodule

//--- hw/register_map.sv
// Rename table of 32 entries; x0 is always ready, flush marks all ready but leaves stale tags in place
module register_map (
    input  logic                                   clk,
    input  logic                                   i_rst_n,
    input  logic                                   i_flush,
    input  logic [dispatch_pkg::REG_IDX_WIDTH-1:0] i_lookup_rs1,
    input  logic [dispatch_pkg::REG_IDX_WIDTH-1:0] i_lookup_rs2,
    output dispatch_pkg::src_t                     o_src1,
    output dispatch_pkg::src_t                     o_src2,
    input  logic                                   i_rename_en,
    input  logic [dispatch_pkg::REG_IDX_WIDTH-1:0] i_rename_rdest,
    input  logic [dispatch_pkg::ROB_TAG_WIDTH-1:0] i_rename_tag,
    input  dispatch_pkg::cdb_t                     i_cdb
);

    // One producer tag and ready bit per architectural register
    dispatch_pkg::src_t map_q [dispatch_pkg::NUM_REGS];

    // Lookup with same-cycle CDB bypass
    assign o_src1 = dispatch_pkg::cdb_merge(map_q[i_lookup_rs1], i_cdb);
    assign o_src2 = dispatch_pkg::cdb_merge(map_q[i_lookup_rs2], i_cdb);

    always_ff @(posedge clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            for (int i = 0; i < dispatch_pkg::NUM_REGS; i++) begin
                map_q[i].tag <= '0;
                map_q[i].rdy <= 1'b1;
            end
        end else if (i_flush) begin
            // Nothing is in flight after a flush
            for (int i = 0; i < dispatch_pkg::NUM_REGS; i++) begin
                map_q[i].rdy <= 1'b1;
            end
        end else begin
            for (int i = 0; i < dispatch_pkg::NUM_REGS; i++) begin
                // Rename beats a broadcast to the same entry
                if (i_rename_en && (i != 0) &&
                    (i_rename_rdest == dispatch_pkg::REG_IDX_WIDTH'(i))) begin
                    map_q[i].tag <= i_rename_tag;
                    map_q[i].rdy <= 1'b0;
                end else begin
                    map_q[i] <= dispatch_pkg::cdb_merge(map_q[i], i_cdb);
                end
            end
        end
    end

endmodule

//--- hw/dispatch_decode_rename.sv
// First dispatch stage; unknown opcodes decode as integer ops with rs1 and rd, held entries track the CDB
module dispatch_decode_rename (
    input  logic                                   clk,
    input  logic                                   i_rst_n,
    input  logic                                   i_flush,
    input  logic                                   i_rs_stall,
    input  logic                                   i_rob_full,
    input  logic                                   i_dispatch_valid,
    input  logic [dispatch_pkg::ADDR_WIDTH-1:0]    i_dispatch_pc,
    input  dispatch_pkg::insn_u                    i_dispatch_insn,
    input  logic [dispatch_pkg::ROB_TAG_WIDTH-1:0] i_rob_tag,
    input  dispatch_pkg::src_t                     i_src [0:1],
    input  dispatch_pkg::cdb_t                     i_cdb,
    output logic                                   o_dispatch_stall,
    output logic [dispatch_pkg::REG_IDX_WIDTH-1:0] o_lookup_rs1,
    output logic [dispatch_pkg::REG_IDX_WIDTH-1:0] o_lookup_rs2,
    output logic [dispatch_pkg::REG_IDX_WIDTH-1:0] o_rename_rdest,
    output logic                                   o_rename_en,
    output logic                                   o_alloc_en,
    output logic                                   o_rob_enq_en,
    output dispatch_pkg::rob_enq_t                 o_rob_enq,
    output logic                                   o_stage_valid,
    output dispatch_pkg::rs_enq_t                  o_stage
);

    logic                  accept;
    dispatch_pkg::rob_op_e op;
    logic                  use_rs1;
    logic                  use_rs2;
    logic                  use_rd;
    dispatch_pkg::src_t    src1;
    dispatch_pkg::src_t    src2;
    logic                  stage_valid_q;
    dispatch_pkg::rob_enq_t rob_q;
    dispatch_pkg::rs_enq_t  stage_q;

    // Op class and operand usage from the opcode
    always_comb begin
        op      = dispatch_pkg::ROB_OP_INT;
        use_rs1 = 1'b1;
        use_rs2 = 1'b0;
        use_rd  = 1'b1;
        case (i_dispatch_insn.i.opcode)
            dispatch_pkg::OPC_OP: use_rs2 = 1'b1;
            dispatch_pkg::OPC_LOAD: op = dispatch_pkg::ROB_OP_LD;
            dispatch_pkg::OPC_STORE: begin
                op      = dispatch_pkg::ROB_OP_ST;
                use_rs2 = 1'b1;
                use_rd  = 1'b0;
            end
            dispatch_pkg::OPC_BRANCH: begin
                op      = dispatch_pkg::ROB_OP_BR;
                use_rs2 = 1'b1;
                use_rd  = 1'b0;
            end
            dispatch_pkg::OPC_JALR: op = dispatch_pkg::ROB_OP_BR;
            dispatch_pkg::OPC_JAL: begin
                op      = dispatch_pkg::ROB_OP_BR;
                use_rs1 = 1'b0;
            end
            // Upper immediates read no register
            dispatch_pkg::OPC_LUI,
            dispatch_pkg::OPC_AUIPC: use_rs1 = 1'b0;
            default: ;
        endcase
    end

    assign o_dispatch_stall = i_rob_full | i_rs_stall;
    assign accept           = i_dispatch_valid & ~o_dispatch_stall;

    // Sources sit in the same bits in every format
    assign o_lookup_rs1   = i_dispatch_insn.i.rs1;
    assign o_lookup_rs2   = i_dispatch_insn.r.rs2;
    assign o_rename_rdest = i_dispatch_insn.i.rd;
    // x0 is never renamed
    assign o_rename_en    = accept & use_rd & (i_dispatch_insn.i.rd != '0);
    assign o_alloc_en     = accept;

    // Unused operands never wait
    assign src1 = use_rs1 ? i_src[0] : '{tag: '0, rdy: 1'b1};
    assign src2 = use_rs2 ? i_src[1] : '{tag: '0, rdy: 1'b1};

    always_ff @(posedge clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            stage_valid_q <= 1'b0;
        end else if (i_flush) begin
            stage_valid_q <= 1'b0;
        end else if (!i_rs_stall) begin
            stage_valid_q <= accept;
        end
    end

    // Stage payload, held sources keep catching broadcasts
    always_ff @(posedge clk) begin
        if (accept) begin
            rob_q.op        <= op;
            rob_q.pc        <= i_dispatch_pc;
            rob_q.rdest     <= use_rd ? i_dispatch_insn.i.rd : '0;
            rob_q.tag       <= i_rob_tag;
            stage_q.opcode  <= i_dispatch_insn.i.opcode;
            stage_q.pc      <= i_dispatch_pc;
            stage_q.insn    <= i_dispatch_insn;
            stage_q.dst_tag <= i_rob_tag;
            stage_q.src1    <= src1;
            stage_q.src2    <= src2;
        end else begin
            stage_q.src1 <= dispatch_pkg::cdb_merge(stage_q.src1, i_cdb);
            stage_q.src2 <= dispatch_pkg::cdb_merge(stage_q.src2, i_cdb);
        end
    end

    // ROB enqueue happens as the entry moves to the second stage
    assign o_rob_enq_en  = stage_valid_q & ~i_rs_stall;
    assign o_rob_enq     = rob_q;
    assign o_stage_valid = stage_valid_q;
    assign o_stage       = stage_q;

endmodule

//--- hw/dispatch_map_enqueue.sv
// Second dispatch stage; output is registered, so a broadcast in the enqueue cycle itself is not merged
module dispatch_map_enqueue (
    input  logic                  clk,
    input  logic                  i_rst_n,
    input  logic                  i_flush,
    input  logic                  i_rs_stall,
    input  logic                  i_stage_valid,
    input  dispatch_pkg::rs_enq_t i_stage,
    input  dispatch_pkg::cdb_t    i_cdb,
    output logic                  o_rs_en,
    output dispatch_pkg::rs_enq_t o_rs_enq
);

    logic                  load;
    logic                  valid_q;
    dispatch_pkg::rs_enq_t stage_merged;
    dispatch_pkg::rs_enq_t rs_q;

    // Stage moves in whenever the RS is not stalling
    assign load = i_stage_valid & ~i_rs_stall;

    // Incoming entry with this cycle's broadcast applied
    always_comb begin
        stage_merged      = i_stage;
        stage_merged.src1 = dispatch_pkg::cdb_merge(i_stage.src1, i_cdb);
        stage_merged.src2 = dispatch_pkg::cdb_merge(i_stage.src2, i_cdb);
    end

    always_ff @(posedge clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            valid_q <= 1'b0;
        end else if (i_flush) begin
            valid_q <= 1'b0;
        end else if (!i_rs_stall) begin
            valid_q <= i_stage_valid;
        end
    end

    // Held entry keeps merging broadcasts until it leaves
    always_ff @(posedge clk) begin
        if (load) begin
            rs_q <= stage_merged;
        end else begin
            rs_q.src1 <= dispatch_pkg::cdb_merge(rs_q.src1, i_cdb);
            rs_q.src2 <= dispatch_pkg::cdb_merge(rs_q.src2, i_cdb);
        end
    end

    // RS enqueue
    assign o_rs_en  = valid_q & ~i_rs_stall;
    assign o_rs_enq = rs_q;

endmodule

//--- hw/dispatch_top.sv
// Dispatch top; caller must only retire while a tag is allocated, and flush discards all in flight
module dispatch_top (
    input  logic                                clk,
    input  logic                                i_rst_n,
    input  logic                                i_flush,
    input  logic                                i_rs_stall,
    input  logic                                i_dispatch_valid,
    input  logic [dispatch_pkg::ADDR_WIDTH-1:0] i_dispatch_pc,
    input  dispatch_pkg::insn_u                 i_dispatch_insn,
    input  dispatch_pkg::cdb_t                  i_cdb,
    input  logic                                i_retire_en,
    output logic                                o_dispatch_stall,
    output logic                                o_rob_enq_en,
    output dispatch_pkg::rob_enq_t              o_rob_enq,
    output logic                                o_rs_en,
    output dispatch_pkg::rs_enq_t               o_rs_enq
);

    // Register map lookup and rename
    logic [dispatch_pkg::REG_IDX_WIDTH-1:0] lookup_rs1;
    logic [dispatch_pkg::REG_IDX_WIDTH-1:0] lookup_rs2;
    dispatch_pkg::src_t                     lookup_src [0:1];
    logic                                   rename_en;
    logic [dispatch_pkg::REG_IDX_WIDTH-1:0] rename_rdest;

    // Tag allocator
    logic                                   alloc_en;
    logic [dispatch_pkg::ROB_TAG_WIDTH-1:0] tail_tag;
    logic                                   rob_full;

    // First to second stage
    logic                                   stage_valid;
    dispatch_pkg::rs_enq_t                  stage;

    // Decode and rename
    dispatch_decode_rename u_decode_rename (
        .clk              (clk),
        .i_rst_n          (i_rst_n),
        .i_flush          (i_flush),
        .i_rs_stall       (i_rs_stall),
        .i_rob_full       (rob_full),
        .i_dispatch_valid (i_dispatch_valid),
        .i_dispatch_pc    (i_dispatch_pc),
        .i_dispatch_insn  (i_dispatch_insn),
        .i_rob_tag        (tail_tag),
        .i_src            (lookup_src),
        .i_cdb            (i_cdb),
        .o_dispatch_stall (o_dispatch_stall),
        .o_lookup_rs1     (lookup_rs1),
        .o_lookup_rs2     (lookup_rs2),
        .o_rename_rdest   (rename_rdest),
        .o_rename_en      (rename_en),
        .o_alloc_en       (alloc_en),
        .o_rob_enq_en     (o_rob_enq_en),
        .o_rob_enq        (o_rob_enq),
        .o_stage_valid    (stage_valid),
        .o_stage          (stage)
    );

    // Map and enqueue
    dispatch_map_enqueue u_map_enqueue (
        .clk           (clk),
        .i_rst_n       (i_rst_n),
        .i_flush       (i_flush),
        .i_rs_stall    (i_rs_stall),
        .i_stage_valid (stage_valid),
        .i_stage       (stage),
        .i_cdb         (i_cdb),
        .o_rs_en       (o_rs_en),
        .o_rs_enq      (o_rs_enq)
    );

    // Renames use the tail tag the allocator hands out this cycle
    register_map u_register_map (
        .clk            (clk),
        .i_rst_n        (i_rst_n),
        .i_flush        (i_flush),
        .i_lookup_rs1   (lookup_rs1),
        .i_lookup_rs2   (lookup_rs2),
        .o_src1         (lookup_src[0]),
        .o_src2         (lookup_src[1]),
        .i_rename_en    (rename_en),
        .i_rename_rdest (rename_rdest),
        .i_rename_tag   (tail_tag),
        .i_cdb          (i_cdb)
    );

    rob_tag_alloc u_rob_tag_alloc (
        .clk         (clk),
        .i_rst_n     (i_rst_n),
        .i_flush     (i_flush),
        .i_alloc_en  (alloc_en),
        .i_retire_en (i_retire_en),
        .o_tail_tag  (tail_tag),
        .o_full      (rob_full)
    );

endmodule

//--- dv/dispatch_tb.sv
// Random dispatch test from a fixed LFSR seed; register indices stay in x0..x7 to force dependencies
module dispatch_tb;
    timeunit 1ns;
    timeprecision 100ps;

    localparam int NUM_CYCLES = 4000;
    localparam int CLK_PERIOD = 20;
    localparam int TIMEOUT_NS = (NUM_CYCLES + 10) * CLK_PERIOD + 1000;

    logic                                   clk;
    logic                                   i_rst_n;
    logic                                   i_flush;
    logic                                   i_rs_stall;
    logic                                   i_dispatch_valid;
    logic [dispatch_pkg::ADDR_WIDTH-1:0]    i_dispatch_pc;
    dispatch_pkg::insn_u                    i_dispatch_insn;
    dispatch_pkg::cdb_t                     i_cdb;
    logic                                   i_retire_en;
    logic                                   o_dispatch_stall;
    logic                                   o_rob_enq_en;
    dispatch_pkg::rob_enq_t                 o_rob_enq;
    logic                                   o_rs_en;
    dispatch_pkg::rs_enq_t                  o_rs_enq;

    // Reference model state
    logic [15:0]                            lfsr;
    int                                     count;
    logic [dispatch_pkg::ROB_TAG_WIDTH-1:0] next_tag;
    logic [dispatch_pkg::ROB_TAG_WIDTH-1:0] map_tag [dispatch_pkg::NUM_REGS];
    logic                                   map_rdy [dispatch_pkg::NUM_REGS];
    logic                                   s1_valid;
    logic                                   s2_valid;
    dispatch_pkg::rob_enq_t                 rob_q [$];
    dispatch_pkg::rs_enq_t                  rs_q [$];
    int                                     errors;
    int                                     checks;

    dispatch_top u_dut (.*);

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // Galois LFSR, one step per bit taken
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] r;
        logic        lsb;
        r = '0;
        for (int i = 0; i < n; i++) begin
            lsb  = lfsr[0];
            r    = {r[30:0], lsb};
            lfsr = lfsr >> 1;
            if (lsb) lfsr = lfsr ^ 16'hB400;
        end
        return r;
    endfunction

    // Selectors past the known set keep a random opcode
    function automatic logic [6:0] opcode_for(input logic [3:0] sel, input logic [6:0] other);
        case (sel)
            4'd0: return dispatch_pkg::OPC_LOAD;
            4'd1: return dispatch_pkg::OPC_OPIMM;
            4'd2: return dispatch_pkg::OPC_AUIPC;
            4'd3: return dispatch_pkg::OPC_STORE;
            4'd4, 4'd9: return dispatch_pkg::OPC_OP;
            4'd5: return dispatch_pkg::OPC_LUI;
            4'd6: return dispatch_pkg::OPC_BRANCH;
            4'd7: return dispatch_pkg::OPC_JALR;
            4'd8: return dispatch_pkg::OPC_JAL;
            default: return other;
        endcase
    endfunction

    // RV32I format rules, packed as {op class, reads rs1, reads rs2, writes rd}
    function automatic logic [4:0] decode_class(input logic [6:0] opc);
        case (opc)
            dispatch_pkg::OPC_OP:     return {dispatch_pkg::ROB_OP_INT, 3'b111};
            dispatch_pkg::OPC_LOAD:   return {dispatch_pkg::ROB_OP_LD, 3'b101};
            dispatch_pkg::OPC_STORE:  return {dispatch_pkg::ROB_OP_ST, 3'b110};
            dispatch_pkg::OPC_BRANCH: return {dispatch_pkg::ROB_OP_BR, 3'b110};
            dispatch_pkg::OPC_JALR:   return {dispatch_pkg::ROB_OP_BR, 3'b101};
            dispatch_pkg::OPC_JAL:    return {dispatch_pkg::ROB_OP_BR, 3'b001};
            // U-type reads no register
            dispatch_pkg::OPC_LUI,
            dispatch_pkg::OPC_AUIPC:  return {dispatch_pkg::ROB_OP_INT, 3'b001};
            default:                  return {dispatch_pkg::ROB_OP_INT, 3'b101};
        endcase
    endfunction

    // A ready source may carry any tag
    function automatic bit src_match(input dispatch_pkg::src_t got, input dispatch_pkg::src_t exp);
        return (got.rdy === exp.rdy) && (exp.rdy || (got.tag === exp.tag));
    endfunction

    task automatic report_mismatch(input string msg);
        $display("Mismatch at %0t ns: %s", $time, msg);
        errors++;
    endtask

    task automatic drive_inputs();
        logic [31:0] tmp;
        logic [31:0] word;
        i_flush          = (rand_bits(8) == 0);
        i_rs_stall       = (rand_bits(2) == 0);
        i_dispatch_valid = (rand_bits(3) != 0);
        tmp              = rand_bits(30);
        i_dispatch_pc    = {tmp[29:0], 2'b00};
        word             = rand_bits(32);
        // Three 3-bit register indices for rd, rs1 and rs2
        tmp              = rand_bits(9);
        word[11:7]       = {2'b00, tmp[2:0]};
        word[19:15]      = {2'b00, tmp[5:3]};
        word[24:20]      = {2'b00, tmp[8:6]};
        tmp              = rand_bits(4);
        word[6:0]        = opcode_for(tmp[3:0], word[31:25]);
        i_dispatch_insn  = word;
        tmp              = rand_bits(5);
        i_cdb.valid      = tmp[4];
        i_cdb.tag        = tmp[3:0];
        // Retire only while a tag is held
        i_retire_en      = (count != 0) && (rand_bits(2) == 0);
    endtask

    // Checks outputs for this cycle, then advances the model across the next edge
    task automatic check_and_step();
        dispatch_pkg::rob_enq_t rob_exp;
        dispatch_pkg::rs_enq_t  rs_exp;
        dispatch_pkg::rs_enq_t  entry;
        logic [4:0]             dec;
        logic                   accept;
        logic                   exp_stall;
        logic                   exp_rob_en;
        logic                   exp_rs_en;
        logic [4:0]             rs1;
        logic [4:0]             rs2;
        logic [4:0]             rd;
        exp_stall  = (count == dispatch_pkg::ROB_DEPTH) || i_rs_stall;
        accept     = i_dispatch_valid && !exp_stall;
        exp_rob_en = s1_valid && !i_rs_stall;
        exp_rs_en  = s2_valid && !i_rs_stall;
        checks++;
        if (o_dispatch_stall !== exp_stall)
            report_mismatch($sformatf("stall %b expected %b", o_dispatch_stall, exp_stall));
        if (o_rob_enq_en !== exp_rob_en)
            report_mismatch($sformatf("ROB enable %b expected %b", o_rob_enq_en, exp_rob_en));
        if (o_rs_en !== exp_rs_en)
            report_mismatch($sformatf("RS enable %b expected %b", o_rs_en, exp_rs_en));
        if (exp_rob_en) begin
            rob_exp = rob_q.pop_front();
            if (o_rob_enq !== rob_exp)
                report_mismatch($sformatf("ROB entry %h expected %h", o_rob_enq, rob_exp));
        end
        if (exp_rs_en) begin
            rs_exp = rs_q.pop_front();
            if ({o_rs_enq.opcode, o_rs_enq.pc, o_rs_enq.insn, o_rs_enq.dst_tag} !==
                {rs_exp.opcode, rs_exp.pc, rs_exp.insn, rs_exp.dst_tag} ||
                !src_match(o_rs_enq.src1, rs_exp.src1) ||
                !src_match(o_rs_enq.src2, rs_exp.src2))
                report_mismatch($sformatf("RS entry %h expected %h", o_rs_enq, rs_exp));
        end
        if (i_flush) begin
            // Everything in flight is dropped
            rob_q.delete();
            rs_q.delete();
            s1_valid = 1'b0;
            s2_valid = 1'b0;
            count    = 0;
            next_tag = '0;
            for (int i = 0; i < dispatch_pkg::NUM_REGS; i++) map_rdy[i] = 1'b1;
            return;
        end
        dec = decode_class(i_dispatch_insn.r.opcode);
        rs1 = i_dispatch_insn.r.rs1;
        rs2 = i_dispatch_insn.r.rs2;
        rd  = i_dispatch_insn.r.rd;
        // Lookup sees the map before this edge
        rob_exp.op          = dispatch_pkg::rob_op_e'(dec[4:3]);
        rob_exp.pc          = i_dispatch_pc;
        rob_exp.rdest       = dec[0] ? rd : 5'd0;
        rob_exp.tag         = next_tag;
        rs_exp.opcode       = i_dispatch_insn.r.opcode;
        rs_exp.pc           = i_dispatch_pc;
        rs_exp.insn         = i_dispatch_insn;
        rs_exp.dst_tag      = next_tag;
        rs_exp.src1.tag     = dec[2] ? map_tag[rs1] : '0;
        rs_exp.src1.rdy     = dec[2] ? map_rdy[rs1] : 1'b1;
        rs_exp.src2.tag     = dec[1] ? map_tag[rs2] : '0;
        rs_exp.src2.rdy     = dec[1] ? map_rdy[rs2] : 1'b1;
        for (int i = 1; i < dispatch_pkg::NUM_REGS; i++) begin
            // Rename of the same register wins over the broadcast
            if (accept && dec[0] && (int'(rd) == i)) begin
                map_tag[i] = next_tag;
                map_rdy[i] = 1'b0;
            end else if (i_cdb.valid && (map_tag[i] == i_cdb.tag)) begin
                map_rdy[i] = 1'b1;
            end
        end
        if (accept) begin
            rob_q.push_back(rob_exp);
            rs_q.push_back(rs_exp);
            next_tag = next_tag + dispatch_pkg::ROB_TAG_WIDTH'(1);
        end
        // Broadcast reaches every entry still pending, the new one too
        foreach (rs_q[k]) begin
            entry = rs_q[k];
            if (i_cdb.valid && (entry.src1.tag == i_cdb.tag)) entry.src1.rdy = 1'b1;
            if (i_cdb.valid && (entry.src2.tag == i_cdb.tag)) entry.src2.rdy = 1'b1;
            rs_q[k] = entry;
        end
        count = count + int'(accept) - int'(i_retire_en);
        if (!i_rs_stall) begin
            s2_valid = s1_valid;
            s1_valid = accept;
        end
    endtask

    initial begin
        lfsr             = 16'd27162;
        i_rst_n          = 1'b0;
        i_flush          = 1'b0;
        i_rs_stall       = 1'b0;
        i_dispatch_valid = 1'b0;
        i_dispatch_pc    = '0;
        i_dispatch_insn  = '0;
        i_cdb            = '0;
        i_retire_en      = 1'b0;
        count            = 0;
        next_tag         = '0;
        s1_valid         = 1'b0;
        s2_valid         = 1'b0;
        errors           = 0;
        checks           = 0;
        for (int i = 0; i < dispatch_pkg::NUM_REGS; i++) begin
            map_tag[i] = '0;
            map_rdy[i] = 1'b1;
        end
        repeat (2) @(posedge clk);
        #2 i_rst_n = 1'b1;
        for (int cyc = 0; cyc < NUM_CYCLES; cyc++) begin
            @(posedge clk);
            #2 drive_inputs();
            // Outputs settle well before the falling edge
            @(negedge clk);
            check_and_step();
        end
        $display("Summary: %0d cycles, %0d checks, %0d errors", NUM_CYCLES, checks, errors);
        if (errors == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

    // Watchdog
    initial begin
        #(TIMEOUT_NS);
        $display("Timeout: run did not finish within %0d ns", TIMEOUT_NS);
        $display("*** TEST FAILED ***");
        $finish;
    end

endmodule

//--- files.f
hw/dispatch_pkg.sv
hw/rob_tag_alloc.sv
hw/register_map.sv
hw/dispatch_decode_rename.sv
hw/dispatch_map_enqueue.sv
hw/dispatch_top.sv
dv/dispatch_tb.sv

//--- run.sh
#!/bin/sh
# Build and run the dispatch testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --top-module dispatch_tb -f files.f
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

out=$(./obj_dir/Vdispatch_tb)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if echo "$out" | grep -qF '*** TEST PASSED ***'; then
    exit 0
fi
exit 1
